/* design/fpu_cfg.svh */
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Issue queue depth, also the instruction credits granted at reset.
`define FPU_IQ_DEPTH 4

// Result credits held toward the consumer at reset.
`define FPU_RES_CREDITS 2

`define FPU_NREGS 32

`endif

/* design/fpu_pkg.sv */
package fpu_pkg;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] operand; // Integer source for fmv.w.x.
  } fpu_issue_t;

  typedef enum logic [3:0] {
    op_none,
    op_fsgnj,
    op_fsgnjn,
    op_fsgnjx,
    op_fmin,
    op_fmax,
    op_feq,
    op_flt,
    op_fle,
    op_fclass,
    op_fmv_x_w,
    op_fmv_w_x
  } fpu_opcode_e;

  typedef struct packed {
    fpu_opcode_e op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic        frden1;
    logic        frden2;
    logic        fwren;
    logic        wren;
    logic        valid;
  } fpu_decode_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
    logic        int_dest;
    logic        illegal;
  } fpu_resp_t;

  localparam logic [6:0] opcode_fp = 7'b1010011;
  localparam logic [1:0] fmt_s = 2'b00;

  localparam logic [4:0] funct5_fsgnj = 5'b00100;
  localparam logic [4:0] funct5_fminmax = 5'b00101;
  localparam logic [4:0] funct5_fcomp = 5'b10100;
  localparam logic [4:0] funct5_fmv_f2i = 5'b11100;
  localparam logic [4:0] funct5_fmv_i2f = 5'b11110;

  localparam logic [2:0] funct3_fsgnj = 3'b000;
  localparam logic [2:0] funct3_fsgnjn = 3'b001;
  localparam logic [2:0] funct3_fsgnjx = 3'b010;
  localparam logic [2:0] funct3_fmin = 3'b000;
  localparam logic [2:0] funct3_fmax = 3'b001;
  localparam logic [2:0] funct3_fle = 3'b000;
  localparam logic [2:0] funct3_flt = 3'b001;
  localparam logic [2:0] funct3_feq = 3'b010;
  localparam logic [2:0] funct3_fmv = 3'b000;
  localparam logic [2:0] funct3_fclass = 3'b001;

endpackage

/* design/fpu_op_if.sv */
`timescale 1ns/1ps

interface fpu_op_if import fpu_pkg::*; ();

  fpu_opcode_e op;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] operand;

  // Driven back combinationally by the execute block.
  logic [31:0] result;
  logic        int_dest;
  logic        invalid;

  modport seq (
    output op, rs1_data, rs2_data, operand,
    input  result, int_dest, invalid
  );

  modport exe (
    input  op, rs1_data, rs2_data, operand,
    output result, int_dest, invalid
  );

endinterface

/* design/fpu_issue_queue.sv */
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_issue_queue import fpu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       push_i,
  input  fpu_issue_t data_i,
  input  logic       pop_i,
  output fpu_issue_t data_o,
  output logic       empty_o
);

  localparam int DEPTH = `FPU_IQ_DEPTH;
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  fpu_issue_t     mem [DEPTH];
  logic [PW-1:0]  wr_ptr;
  logic [PW-1:0]  rd_ptr;
  logic [CW-1:0]  count;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    next_ptr = (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clock) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push_i) wr_ptr <= next_ptr(wr_ptr);
      if (pop_i) rd_ptr <= next_ptr(rd_ptr);
      count <= count + CW'(push_i) - CW'(pop_i); // Source credits bound this.
    end
  end

  assign data_o = mem[rd_ptr];
  assign empty_o = (count == '0);

endmodule

/* design/fpu_decode.sv */
`timescale 1ns/1ps

module fpu_decode import fpu_pkg::*; (
  input  logic [31:0] instr_i,
  output fpu_decode_t dec_o
);

  logic [6:0] opcode;
  logic [4:0] funct5;
  logic [2:0] funct3;
  logic [1:0] fmt;

  assign opcode = instr_i[6:0];
  assign funct5 = instr_i[31:27];
  assign funct3 = instr_i[14:12];
  assign fmt = instr_i[26:25];

  always_comb begin
    dec_o.op = op_none;
    dec_o.rs1 = instr_i[19:15];
    dec_o.rs2 = instr_i[24:20];
    dec_o.rd = instr_i[11:7];
    dec_o.funct3 = funct3;
    dec_o.frden1 = 1'b0;
    dec_o.frden2 = 1'b0;
    dec_o.fwren = 1'b0;
    dec_o.wren = 1'b0;
    dec_o.valid = (opcode == opcode_fp) && (fmt == fmt_s); // Single precision only.

    case (funct5)
      funct5_fsgnj: begin
        dec_o.fwren = 1'b1;
        dec_o.frden1 = 1'b1;
        dec_o.frden2 = 1'b1;
        case (funct3)
          funct3_fsgnj: dec_o.op = op_fsgnj;
          funct3_fsgnjn: dec_o.op = op_fsgnjn;
          funct3_fsgnjx: dec_o.op = op_fsgnjx;
          default: dec_o.valid = 1'b0;
        endcase
      end
      funct5_fminmax: begin
        dec_o.fwren = 1'b1;
        dec_o.frden1 = 1'b1;
        dec_o.frden2 = 1'b1;
        case (funct3)
          funct3_fmin: dec_o.op = op_fmin;
          funct3_fmax: dec_o.op = op_fmax;
          default: dec_o.valid = 1'b0;
        endcase
      end
      funct5_fcomp: begin
        dec_o.wren = 1'b1;
        dec_o.frden1 = 1'b1;
        dec_o.frden2 = 1'b1;
        case (funct3)
          funct3_feq: dec_o.op = op_feq;
          funct3_flt: dec_o.op = op_flt;
          funct3_fle: dec_o.op = op_fle;
          default: dec_o.valid = 1'b0;
        endcase
      end
      funct5_fmv_f2i: begin
        dec_o.wren = 1'b1;
        dec_o.frden1 = 1'b1;
        case (funct3)
          funct3_fmv: dec_o.op = op_fmv_x_w;
          funct3_fclass: dec_o.op = op_fclass;
          default: dec_o.valid = 1'b0;
        endcase
      end
      funct5_fmv_i2f: begin
        dec_o.fwren = 1'b1;
        if (funct3 == funct3_fmv) dec_o.op = op_fmv_w_x;
        else dec_o.valid = 1'b0;
      end
      default: dec_o.valid = 1'b0;
    endcase

    // Illegal instructions read and write nothing.
    if (!dec_o.valid) begin
      dec_o.op = op_none;
      dec_o.frden1 = 1'b0;
      dec_o.frden2 = 1'b0;
      dec_o.fwren = 1'b0;
      dec_o.wren = 1'b0;
    end
  end

endmodule

/* design/fpu_regfile.sv */
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  raddr1_i,
  input  logic [4:0]  raddr2_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  logic [31:0] regs [`FPU_NREGS];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `FPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

/* design/fpu_execute.sv */
`timescale 1ns/1ps

module fpu_execute import fpu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  fpu_op_if.exe      op,
  input  logic       fire_i,
  input  logic       fflags_clear_i,
  output logic [4:0] fflags_o
);

  localparam logic [31:0] canonical_nan = 32'h7fc00000;

  logic [31:0] a;
  logic [31:0] b;
  logic        nan_a;
  logic        nan_b;
  logic        snan_a;
  logic        snan_b;
  logic        any_nan;
  logic        both_zero;
  logic        ord_lt;
  logic        cmp_eq;
  logic        cmp_lt;
  logic        nv;

  function automatic logic [9:0] classify(input logic [31:0] x);
    logic exp_max;
    logic exp_zero;
    logic man_zero;
    logic [9:0] mask;
    exp_max = &x[30:23];
    exp_zero = ~|x[30:23];
    man_zero = ~|x[22:0];
    mask = '0;
    if (exp_max && !man_zero) mask[x[22] ? 9 : 8] = 1'b1; // Quiet bit picks qNaN.
    else if (exp_max) mask[x[31] ? 0 : 7] = 1'b1;
    else if (exp_zero && man_zero) mask[x[31] ? 3 : 4] = 1'b1;
    else if (exp_zero) mask[x[31] ? 2 : 5] = 1'b1;
    else mask[x[31] ? 1 : 6] = 1'b1;
    return mask;
  endfunction

  assign a = op.rs1_data;
  assign b = op.rs2_data;

  assign nan_a = (&a[30:23]) && (|a[22:0]);
  assign nan_b = (&b[30:23]) && (|b[22:0]);
  assign snan_a = nan_a && !a[22];
  assign snan_b = nan_b && !b[22];
  assign any_nan = nan_a || nan_b;
  assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);

  // Total order on non-NaN values, -0 below +0.
  assign ord_lt = (a[31] != b[31]) ? a[31] :
                  a[31] ? (b[30:0] < a[30:0]) : (a[30:0] < b[30:0]);

  assign cmp_eq = (a == b) || both_zero;
  assign cmp_lt = ord_lt && !both_zero; // IEEE compare, zeros equal.

  always_comb begin
    op.result = '0;
    op.int_dest = 1'b0;
    op.invalid = 1'b0;
    case (op.op)
      op_fsgnj: op.result = {b[31], a[30:0]};
      op_fsgnjn: op.result = {~b[31], a[30:0]};
      op_fsgnjx: op.result = {a[31] ^ b[31], a[30:0]};
      op_fmin, op_fmax: begin
        if (nan_a && nan_b) op.result = canonical_nan;
        else if (nan_a) op.result = b;
        else if (nan_b) op.result = a;
        else op.result = (ord_lt == (op.op == op_fmin)) ? a : b;
        op.invalid = snan_a || snan_b;
      end
      op_feq: begin
        op.result = {31'b0, !any_nan && cmp_eq};
        op.int_dest = 1'b1;
        op.invalid = snan_a || snan_b;
      end
      op_flt: begin
        op.result = {31'b0, !any_nan && cmp_lt};
        op.int_dest = 1'b1;
        op.invalid = any_nan; // Signaling compare.
      end
      op_fle: begin
        op.result = {31'b0, !any_nan && (cmp_lt || cmp_eq)};
        op.int_dest = 1'b1;
        op.invalid = any_nan;
      end
      op_fclass: begin
        op.result = {22'b0, classify(a)};
        op.int_dest = 1'b1;
      end
      op_fmv_x_w: begin
        op.result = a;
        op.int_dest = 1'b1;
      end
      op_fmv_w_x: op.result = op.operand;
      default: ;
    endcase
  end

  // Only NV can be raised by these operations.
  always_ff @(posedge clock) begin
    if (!reset) begin
      nv <= 1'b0;
    end else if (fflags_clear_i) begin
      nv <= 1'b0;
    end else if (fire_i) begin
      nv <= nv | op.invalid;
    end
  end

  assign fflags_o = {nv, 4'b0};

endmodule

/* design/fpu_sequencer.sv */
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_sequencer import fpu_pkg::*; #(
  parameter int CW = $clog2(`FPU_RES_CREDITS + 1)
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          empty_i,
  input  fpu_issue_t    issue_i,
  input  logic [CW-1:0] credit_avail_i,
  output logic          pop_o,
  fpu_op_if.seq         op,
  input  logic [31:0]   rdata1_i,
  input  logic [31:0]   rdata2_i,
  output logic [4:0]    raddr1_o,
  output logic [4:0]    raddr2_o,
  output logic          we_o,
  output logic [4:0]    waddr_o,
  output logic [31:0]   wdata_o,
  output logic          fire_o,
  output logic          res_valid_o,
  output fpu_resp_t     res_o
);

  typedef enum logic [1:0] {IDLE, EXEC, RESP} state_e;

  state_e      state;
  fpu_issue_t  issue_q;
  fpu_decode_t dec;
  fpu_decode_t dec_q;
  logic [31:0] rs1_q;
  logic [31:0] rs2_q;
  logic [31:0] operand_q;

  fpu_decode u_decode (
    .instr_i (issue_q.instr),
    .dec_o   (dec)
  );

  // In RESP the current response still takes one credit.
  assign pop_o = !empty_i &&
                 ((state == IDLE && credit_avail_i != '0) ||
                  (state == RESP && credit_avail_i > CW'(1)));

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= IDLE;
      dec_q <= '0;
    end else begin
      case (state)
        EXEC: begin
          state <= RESP;
          dec_q <= dec;
        end
        default: state <= pop_o ? EXEC : IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (pop_o) issue_q <= issue_i;
    if (state == EXEC) begin
      rs1_q <= dec.frden1 ? rdata1_i : '0;
      rs2_q <= dec.frden2 ? rdata2_i : '0;
      operand_q <= issue_q.operand;
    end
  end

  assign raddr1_o = dec.rs1;
  assign raddr2_o = dec.rs2;

  assign op.op = dec_q.op; // Decode already gives op_none when illegal.
  assign op.rs1_data = rs1_q;
  assign op.rs2_data = rs2_q;
  assign op.operand = operand_q;

  assign res_valid_o = (state == RESP);
  assign fire_o = res_valid_o && dec_q.valid;
  assign we_o = fire_o && dec_q.fwren;
  assign waddr_o = dec_q.rd;
  assign wdata_o = op.result;

  assign res_o.rd = dec_q.rd;
  assign res_o.data = dec_q.valid ? op.result : '0;
  assign res_o.int_dest = dec_q.valid && op.int_dest;
  assign res_o.illegal = !dec_q.valid;

endmodule

/* design/fpu_credit_counter.sv */
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_credit_counter #(
  parameter int CW = $clog2(`FPU_RES_CREDITS + 1)
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          take_i,
  input  logic          give_i,
  output logic [CW-1:0] avail_o
);

  logic [CW-1:0] count;

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= CW'(`FPU_RES_CREDITS);
    end else if (take_i && !give_i) begin
      count <= count - 1'b1;
    end else if (give_i && !take_i) begin
      count <= count + 1'b1;
    end
  end

  assign avail_o = count;

endmodule

/* design/fpu_top.sv */
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_top import fpu_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] operand_i,
  output logic        instr_credit_o,
  output logic        res_valid_o,
  output logic [4:0]  res_rd_o,
  output logic [31:0] res_data_o,
  output logic        res_int_o,
  output logic        res_illegal_o,
  input  logic        res_credit_i,
  input  logic        fflags_clear_i,
  output logic [4:0]  fflags_o
);

  localparam int CW = $clog2(`FPU_RES_CREDITS + 1);

  fpu_issue_t    issue_in;
  fpu_issue_t    issue_head;
  logic          empty;
  logic          pop;
  logic [CW-1:0] credit_avail;
  logic [4:0]    raddr1;
  logic [4:0]    raddr2;
  logic [31:0]   rdata1;
  logic [31:0]   rdata2;
  logic          we;
  logic [4:0]    waddr;
  logic [31:0]   wdata;
  logic          fire;
  fpu_resp_t     resp;

  fpu_op_if u_op_if ();

  assign issue_in.instr = instr_i;
  assign issue_in.operand = operand_i;

  fpu_issue_queue u_queue (
    .clock   (clock),
    .reset   (reset),
    .push_i  (instr_valid_i),
    .data_i  (issue_in),
    .pop_i   (pop),
    .data_o  (issue_head),
    .empty_o (empty)
  );

  fpu_regfile u_regfile (
    .clock    (clock),
    .reset    (reset),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (we),
    .waddr_i  (waddr),
    .wdata_i  (wdata)
  );

  fpu_sequencer #(.CW(CW)) u_sequencer (
    .clock          (clock),
    .reset          (reset),
    .empty_i        (empty),
    .issue_i        (issue_head),
    .credit_avail_i (credit_avail),
    .pop_o          (pop),
    .op             (u_op_if.seq),
    .rdata1_i       (rdata1),
    .rdata2_i       (rdata2),
    .raddr1_o       (raddr1),
    .raddr2_o       (raddr2),
    .we_o           (we),
    .waddr_o        (waddr),
    .wdata_o        (wdata),
    .fire_o         (fire),
    .res_valid_o    (res_valid_o),
    .res_o          (resp)
  );

  fpu_execute u_execute (
    .clock          (clock),
    .reset          (reset),
    .op             (u_op_if.exe),
    .fire_i         (fire),
    .fflags_clear_i (fflags_clear_i),
    .fflags_o       (fflags_o)
  );

  // A response spends one credit, the consumer returns it.
  fpu_credit_counter #(.CW(CW)) u_res_credits (
    .clock   (clock),
    .reset   (reset),
    .take_i  (res_valid_o),
    .give_i  (res_credit_i),
    .avail_o (credit_avail)
  );

  assign instr_credit_o = pop; // Each pop frees one queue slot.
  assign res_rd_o = resp.rd;
  assign res_data_o = resp.data;
  assign res_int_o = resp.int_dest;
  assign res_illegal_o = resp.illegal;

endmodule

/* sim/fpu_chk.sv */
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_chk #(
  parameter int CW = $clog2(`FPU_RES_CREDITS + 1)
) (
  input logic          clock,
  input logic          reset,
  input logic          res_valid_i,
  input logic          illegal_i,
  input logic          int_dest_i,
  input logic [CW-1:0] credit_avail_i,
  input logic          we_i,
  input logic          instr_credit_i
);

  // A response always spends a credit the DUT still holds.
  res_credit_a: assert property (@(posedge clock) disable iff (!reset)
    res_valid_i |-> (credit_avail_i != '0))
    else $error("result sent with no result credit held");

  // Writes only for legal FP-destination responses.
  no_illegal_write_a: assert property (@(posedge clock) disable iff (!reset)
    we_i == (res_valid_i && !illegal_i && !int_dest_i))
    else $error("register write does not match the response kind");

  // A pop reaches its response two cycles later.
  credit_pop_a: assert property (@(posedge clock) disable iff (!reset)
    res_valid_i == $past(instr_credit_i, 2))
    else $error("instruction credit outside a pop cycle");

  // Cycle after a pop is EXEC, so no second pop.
  credit_gap_a: assert property (@(posedge clock) disable iff (!reset)
    instr_credit_i |=> !instr_credit_i)
    else $error("instruction credits on two cycles in a row");

endmodule

bind fpu_top fpu_chk u_chk (
  .clock          (clock),
  .reset          (reset),
  .res_valid_i    (res_valid_o),
  .illegal_i      (res_illegal_o),
  .int_dest_i     (res_int_o),
  .credit_avail_i (credit_avail),
  .we_i           (we),
  .instr_credit_i (instr_credit_o)
);

/* sim/fpu_tb.sv */
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_tb import fpu_pkg::*; ();

  localparam logic [31:0] cmp_vals [8] = '{
    32'h00000000, 32'h80000000, 32'h7fc00000, 32'h7f800001,
    32'h3f800000, 32'hc0000000, 32'h7f800000, 32'hffc12345
  };

  // Ordered so that entry i has class bit i.
  localparam logic [31:0] class_vals [10] = '{
    32'hff800000, 32'hc0000000, 32'h80000001, 32'h80000000, 32'h00000000,
    32'h00000001, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000
  };

  logic        clock;
  logic        reset;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] operand_i;
  logic        instr_credit_o;
  logic        res_valid_o;
  logic [4:0]  res_rd_o;
  logic [31:0] res_data_o;
  logic        res_int_o;
  logic        res_illegal_o;
  logic        res_credit_i;
  logic        fflags_clear_i;
  logic [4:0]  fflags_o;

  fpu_resp_t   exp_q [$];
  logic [31:0] ref_regs [`FPU_NREGS];
  logic        model_nv;
  logic [31:0] rng_state;
  logic        hold_credits;
  logic        give_next;
  int          src_credits;
  int          res_credits;
  int          credit_pulses;
  int          resp_count;
  int          sent;
  int          checks;
  int          errors;
  int          cycles;

  fpu_top dut0 (
    .clock          (clock),
    .reset          (reset),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .operand_i      (operand_i),
    .instr_credit_o (instr_credit_o),
    .res_valid_o    (res_valid_o),
    .res_rd_o       (res_rd_o),
    .res_data_o     (res_data_o),
    .res_int_o      (res_int_o),
    .res_illegal_o  (res_illegal_o),
    .res_credit_i   (res_credit_i),
    .fflags_clear_i (fflags_clear_i),
    .fflags_o       (fflags_o)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] encode_fp(input logic [4:0] f5, input logic [2:0] f3,
                                            input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [4:0] rd);
    return {f5, fmt_s, rs2, rs1, f3, rd, opcode_fp};
  endfunction

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
  endfunction

  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // Monotonic unsigned key, -0 just below +0.
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic [31:0] zero_norm(input logic [31:0] x);
    return (x[30:0] == '0) ? 32'h0 : x;
  endfunction

  function automatic logic [31:0] min_max(input logic [31:0] a, input logic [31:0] b,
                                          input logic pick_min);
    if (is_nan(a) && is_nan(b)) return 32'h7fc00000;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    return ((order_key(a) < order_key(b)) == pick_min) ? a : b;
  endfunction

  function automatic logic [9:0] class_mask(input logic [31:0] x);
    int idx;
    if (is_nan(x)) idx = x[22] ? 9 : 8;
    else if (x[30:0] == 31'h7f800000) idx = x[31] ? 0 : 7;
    else if (x[30:0] == '0) idx = x[31] ? 3 : 4;
    else if (x[30:23] == '0) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 1 : 6;
    return 10'b1 << idx;
  endfunction

  // Reference model, run in issue order against ref_regs.
  function automatic fpu_resp_t model_step(input logic [31:0] instr, input logic [31:0] operand);
    fpu_resp_t   r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ka;
    logic [31:0] kb;
    logic        nan_any;
    logic        snan_any;
    logic        legal;
    a = ref_regs[instr[19:15]];
    b = ref_regs[instr[24:20]];
    ka = order_key(zero_norm(a));
    kb = order_key(zero_norm(b));
    nan_any = is_nan(a) || is_nan(b);
    snan_any = is_snan(a) || is_snan(b);
    r = '0;
    r.rd = instr[11:7];
    legal = (instr[6:0] == opcode_fp) && (instr[26:25] == fmt_s);
    case ({instr[31:27], instr[14:12]})
      {funct5_fsgnj, funct3_fsgnj}: r.data = (a & 32'h7fffffff) | (b & 32'h80000000);
      {funct5_fsgnj, funct3_fsgnjn}: r.data = (a & 32'h7fffffff) | (~b & 32'h80000000);
      {funct5_fsgnj, funct3_fsgnjx}: r.data = a ^ (b & 32'h80000000);
      {funct5_fminmax, funct3_fmin}: r.data = min_max(a, b, 1'b1);
      {funct5_fminmax, funct3_fmax}: r.data = min_max(a, b, 1'b0);
      {funct5_fcomp, funct3_feq}: r.data = {31'b0, !nan_any && (ka == kb)};
      {funct5_fcomp, funct3_flt}: r.data = {31'b0, !nan_any && (ka < kb)};
      {funct5_fcomp, funct3_fle}: r.data = {31'b0, !nan_any && (ka <= kb)};
      {funct5_fmv_f2i, funct3_fmv}: r.data = a;
      {funct5_fmv_f2i, funct3_fclass}: r.data = {22'b0, class_mask(a)};
      {funct5_fmv_i2f, funct3_fmv}: r.data = operand;
      default: legal = 1'b0;
    endcase
    r.int_dest = instr[31:27] inside {funct5_fcomp, funct5_fmv_f2i};
    if (!legal) begin
      r.data = '0;
      r.int_dest = 1'b0;
      r.illegal = 1'b1;
    end else begin
      if (!r.int_dest) ref_regs[r.rd] = r.data;
      if (instr[31:27] == funct5_fminmax) model_nv |= snan_any;
      if (instr[31:27] == funct5_fcomp) begin
        model_nv |= (instr[14:12] == funct3_feq) ? snan_any : nan_any; // Signaling compares.
      end
    end
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic match_response();
    fpu_resp_t e;
    expect_true(exp_q.size() != 0, "response arrived with no instruction outstanding");
    expect_true(res_credits > 0, "response sent while the consumer held no credit");
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      compare_value("res_rd_o", {27'b0, res_rd_o}, {27'b0, e.rd});
      compare_value("res_data_o", res_data_o, e.data);
      compare_value("res_int_o", {31'b0, res_int_o}, {31'b0, e.int_dest});
      compare_value("res_illegal_o", {31'b0, res_illegal_o}, {31'b0, e.illegal});
    end
    if (res_credits > 0) res_credits--;
    resp_count++;
  endtask

  // Mid-cycle monitor. Credits to return are decided here.
  always @(negedge clock) begin
    if (reset) begin
      if (instr_credit_o) begin
        src_credits++;
        credit_pulses++;
      end
      if (res_valid_o) match_response();
      give_next = !hold_credits && (res_credits < `FPU_RES_CREDITS);
      if (give_next) res_credits++;
    end
  end

  always @(posedge clock) begin
    #1;
    res_credit_i = give_next;
  end

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic issue(input logic [31:0] instr, input logic [31:0] operand);
    while (src_credits == 0) step();
    exp_q.push_back(model_step(instr, operand));
    instr_valid_i = 1'b1;
    instr_i = instr;
    operand_i = operand;
    src_credits--;
    sent++;
    step();
    instr_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) step();
  endtask

  task automatic check_flags();
    compare_value("fflags_o", {27'b0, fflags_o}, {27'b0, model_nv, 4'b0});
  endtask

  task automatic clear_flags();
    fflags_clear_i = 1'b1;
    step();
    fflags_clear_i = 1'b0;
    model_nv = 1'b0;
    check_flags();
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic move_roundtrip();
    int err0;
    err0 = errors;
    for (int i = 0; i < `FPU_NREGS; i++) begin
      issue(encode_fp(funct5_fmv_i2f, funct3_fmv, 5'd0, 5'd0, 5'(i)), xorshift32());
    end
    for (int i = 0; i < `FPU_NREGS; i++) begin
      issue(encode_fp(funct5_fmv_f2i, funct3_fmv, 5'd0, 5'(i), 5'(i)), 32'h0);
    end
    drain();
    report_test("move round trip", err0);
  endtask

  task automatic sign_inject();
    int          err0;
    logic [31:0] r;
    logic [2:0]  f3;
    err0 = errors;
    for (int n = 0; n < 24; n++) begin
      r = xorshift32();
      f3 = (r[1:0] == 2'd0) ? funct3_fsgnj : (r[1:0] == 2'd1) ? funct3_fsgnjn : funct3_fsgnjx;
      issue(encode_fp(funct5_fsgnj, f3, r[14:10], r[9:5], r[19:15]), 32'h0);
      issue(encode_fp(funct5_fmv_f2i, funct3_fmv, 5'd0, r[19:15], 5'd1), 32'h0);
    end
    drain();
    report_test("sign injection", err0);
  endtask

  task automatic min_max_compare();
    int          err0;
    logic [31:0] ops [5];
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      issue(encode_fp(funct5_fmv_i2f, funct3_fmv, 5'd0, 5'd0, 5'(i + 1)), cmp_vals[i]);
    end
    drain();
    clear_flags();
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8; j++) begin
        ops[0] = encode_fp(funct5_fminmax, funct3_fmin, 5'(j + 1), 5'(i + 1), 5'd16);
        ops[1] = encode_fp(funct5_fminmax, funct3_fmax, 5'(j + 1), 5'(i + 1), 5'd17);
        ops[2] = encode_fp(funct5_fcomp, funct3_feq, 5'(j + 1), 5'(i + 1), 5'd2);
        ops[3] = encode_fp(funct5_fcomp, funct3_flt, 5'(j + 1), 5'(i + 1), 5'd3);
        ops[4] = encode_fp(funct5_fcomp, funct3_fle, 5'(j + 1), 5'(i + 1), 5'd4);
        // One op at a time, so each NV rule is seen alone.
        for (int k = 0; k < 5; k++) begin
          issue(ops[k], 32'h0);
          drain();
          check_flags();
          clear_flags();
        end
      end
    end
    report_test("min max compare", err0);
  endtask

  task automatic classify_values();
    int err0;
    err0 = errors;
    for (int i = 0; i < 10; i++) begin
      issue(encode_fp(funct5_fmv_i2f, funct3_fmv, 5'd0, 5'd0, 5'(i + 20)), class_vals[i]);
    end
    for (int i = 0; i < 10; i++) begin
      issue(encode_fp(funct5_fmv_f2i, funct3_fclass, 5'd0, 5'(i + 20), 5'(i)), 32'h0);
    end
    drain();
    report_test("fclass", err0);
  endtask

  task automatic illegal_instrs();
    int          err0;
    logic [31:0] w;
    err0 = errors;
    w = encode_fp(funct5_fsgnj, funct3_fsgnj, 5'd2, 5'd3, 5'd9);
    issue({w[31:7], 7'b0000111}, 32'h0); // Load opcode.
    issue(w | 32'h0200_0000, 32'h0); // Double format.
    issue(encode_fp(5'b00000, 3'b000, 5'd2, 5'd3, 5'd9), 32'h0); // fadd.
    issue(encode_fp(funct5_fsgnj, 3'b011, 5'd2, 5'd3, 5'd9), 32'h0);
    issue(encode_fp(funct5_fcomp, 3'b011, 5'd2, 5'd3, 5'd9), 32'h0);
    issue(encode_fp(funct5_fmv_i2f, 3'b001, 5'd0, 5'd0, 5'd9), 32'hdeadbeef);
    issue(encode_fp(funct5_fmv_f2i, funct3_fmv, 5'd0, 5'd9, 5'd9), 32'h0);
    drain();
    report_test("illegal instructions", err0);
  endtask

  task automatic result_backpressure();
    int err0;
    int resp0;
    int pulses0;
    int total;
    err0 = errors;
    resp0 = resp_count;
    pulses0 = credit_pulses;
    total = `FPU_IQ_DEPTH + `FPU_RES_CREDITS;
    hold_credits = 1'b1;
    for (int k = 0; k < total; k++) begin
      if (k % 2 == 0) begin
        issue(encode_fp(funct5_fmv_f2i, funct3_fmv, 5'd0, 5'(k + 1), 5'(k)), 32'h0);
      end else begin
        issue(encode_fp(funct5_fsgnj, funct3_fsgnjx, 5'(k + 3), 5'(k), 5'(k + 10)), 32'h0);
      end
    end
    repeat (20) step(); // Nothing further may come out.
    expect_true(resp_count - resp0 <= `FPU_RES_CREDITS,
                "more responses than result credits while credits were withheld");
    expect_true(exp_q.size() == `FPU_IQ_DEPTH,
                "issue queue did not fill while result credits were withheld");
    hold_credits = 1'b0;
    drain();
    expect_true(credit_pulses - pulses0 == total,
                "instruction credit pulses do not match instructions sent");
    report_test("result back-pressure", err0);
  endtask

  initial begin
    cycles = 0;
    while (cycles <= 40 * sent + 200) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    reset = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    operand_i = '0;
    res_credit_i = 1'b0;
    fflags_clear_i = 1'b0;
    rng_state = 32'h703e9662;
    hold_credits = 1'b0;
    give_next = 1'b0;
    model_nv = 1'b0;
    src_credits = `FPU_IQ_DEPTH;
    res_credits = `FPU_RES_CREDITS;
    for (int i = 0; i < `FPU_NREGS; i++) begin
      ref_regs[i] = '0;
    end
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b1;

    move_roundtrip();
    sign_inject();
    min_max_compare();
    classify_values();
    illegal_instrs();
    result_backpressure();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/fpu_pkg.sv
design/fpu_op_if.sv
design/fpu_issue_queue.sv
design/fpu_decode.sv
design/fpu_regfile.sv
design/fpu_execute.sv
design/fpu_sequencer.sv
design/fpu_credit_counter.sv
design/fpu_top.sv
sim/fpu_chk.sv
sim/fpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= fpu_tb
FILELIST  ?= vlog.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
LOG     := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
